//--- test/alu_stimulus.hex
// Columns: op _ operand a _ operand b _ expected result _ flags
// Flags bit 0 is the expected branch bit, bit 1 inserts an idle gap before the vector
00_7fffffff_00000001_80000000_1
00_ffffffff_00000002_00000001_1
01_00000000_00000001_ffffffff_1
01_12345678_02040608_10305070_1
02_f0f0ff00_0ff0f0f0_00f0f000_3
03_f0f00000_0f0f1234_ffff1234_1
04_aaaa5555_ffff0000_55555555_1
05_80000000_00000001_00000001_1
06_80000000_00000001_00000000_1
07_0000abcd_0000abcd_00000000_1
08_0000abcd_0000abcd_00000000_2
09_ffffffff_00000000_00000000_1
0a_ffffffff_00000000_00000000_0
0b_80000000_7fffffff_00000000_0
0c_80000000_7fffffff_00000000_1
0f_7f8010c0_01ff20c0_7f813081_1
10_807f0500_01810a80_817ffb7f_3
0d_05fa8014_03047fec_03fc81ec_1
0e_807fff00_00000000_01000100_1
0e_807fff00_12345601_00000000_1
11_0100ff01_00000000_ff0000ff_3
12_11223344_ffffff00_11223344_1
12_11223344_00000001_00000000_1

//--- sources.f
+incdir+hw
hw/polar_lane_pkg.sv
hw/alu_op_pkg.sv
hw/alu_issue_stage.sv
hw/int_datapath.sv
hw/polar_simd_unit.sv
hw/alu_writeback_stage.sv
hw/polar_alu_top.sv
test/tb_polar_alu.sv

//--- Makefile
# Verilator build and run for the polar ALU testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_polar_alu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(wildcard hw/*.sv hw/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails when the log holds the fail message
run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_polar_alu.sv
/* Self-checking testbench for the two-stage polar ALU.
   Replays the vectors in test/alu_stimulus.hex and checks each result two cycles later. */
`timescale 1ns/1ps
`include "alu_consts.svh"

module tb_polar_alu
    import alu_op_pkg::*;
();

    localparam int MAX_VECS  = 64;
    localparam int VEC_W     = 108;
    localparam int RESET_CYC = 10;

    // One outstanding result and the cycle its request was driven
    typedef struct packed {
        logic [`ALU_XLEN-1:0] result;
        logic                 branch;
        int                   issue_cycle;
    } expect_t;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    alu_op_e              in_op;
    logic [`ALU_XLEN-1:0] operand_a;
    logic [`ALU_XLEN-1:0] operand_b;
    logic                 out_valid;
    logic [`ALU_XLEN-1:0] out_result;
    logic                 out_branch;

    logic [VEC_W-1:0] vec_mem [0:MAX_VECS-1];
    expect_t          expect_q [$];
    int               num_vecs = 0;
    int               checked = 0;
    int               cycle_cnt = 0;
    int               timeout_limit = 2 * MAX_VECS + 50;
    integer           seed = 32'h3a92_6228;

    polar_alu_top u_dut (
        .clk_i       (clk),
        .rst_i       (rst),
        .valid_i     (in_valid),
        .op_i        (in_op),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .valid_o     (out_valid),
        .result_o    (out_result),
        .branch_o    (out_branch)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------
    // Cycle count and hang guard
    // ------------------------------------------------------------

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("Run hung: %0d of %0d vectors checked after %0d cycles",
                     checked, num_vecs, cycle_cnt);
            abort_run();
        end
    end

    // Outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        expect_t exp_item;
        if (!rst && out_valid) begin
            if (expect_q.size() == 0) begin
                $display("valid_o went high with no request outstanding");
                abort_run();
            end else begin
                exp_item = expect_q.pop_front();
                check_value("result_o", out_result, exp_item.result);
                check_value("branch_o", 32'(out_branch), 32'(exp_item.branch));
                check_value("latency", cycle_cnt - exp_item.issue_cycle, 2);
                checked++;
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin
        logic [VEC_W-1:0] vec;
        expect_t          item;
        int               gap_len;

        rst       = 1'b1;
        in_valid  = 1'b0;
        in_op     = ADD;
        operand_a = '0;
        operand_b = '0;

        // Op byte 0xff marks the end of the loaded vectors
        for (int i = 0; i < MAX_VECS; i++) begin
            vec_mem[i] = {8'hff, {(VEC_W-40){1'b0}}, 32'(i)};
        end
        $readmemh("test/alu_stimulus.hex", vec_mem);
        while (num_vecs < MAX_VECS && vec_mem[num_vecs][107:100] != 8'hff) begin
            num_vecs++;
        end
        if (num_vecs == 0) begin
            $display("No vectors could be loaded from test/alu_stimulus.hex");
            abort_run();
        end
        timeout_limit = 2 * num_vecs + 50;

        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b0;

        // Idle outputs after reset
        @(negedge clk);
        check_value("valid_o", 32'(out_valid), 0);
        check_value("result_o", out_result, 0);
        check_value("branch_o", 32'(out_branch), 0);

        for (int i = 0; i < num_vecs; i++) begin
            vec = vec_mem[i];
            if (vec[1]) begin
                gap_len = 1 + ($unsigned($random(seed)) % 3);
                repeat (gap_len) begin
                    @(posedge clk);
                    in_valid <= 1'b0;
                end
            end
            @(posedge clk);
            in_valid  <= 1'b1;
            in_op     <= alu_op_e'(vec[104:100]);
            operand_a <= vec[99:68];
            operand_b <= vec[67:36];
            item.result      = vec[35:4];
            item.branch      = vec[0];
            item.issue_cycle = cycle_cnt + 1;
            expect_q.push_back(item);
        end
        @(posedge clk);
        in_valid <= 1'b0;

        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);

        $display("** PASS **");
        $finish;
    end

endmodule

//--- hw/polar_alu_top.sv
/* Two-stage integer and polar SIMD ALU.
   A strobed operation returns its result and branch bit two cycles later. */
`timescale 1ns/1ps
`include "alu_consts.svh"

module polar_alu_top
    import alu_op_pkg::*;
    import polar_lane_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  alu_op_e              op_i,
    input  logic [`ALU_XLEN-1:0] operand_a_i,
    input  logic [`ALU_XLEN-1:0] operand_b_i,
    output logic                 valid_o,
    output logic [`ALU_XLEN-1:0] result_o,
    output logic                 branch_o
);

    alu_req_t             issue_req;
    logic [`ALU_XLEN-1:0] int_result;
    logic [`ALU_XLEN-1:0] polar_result;
    logic                 int_branch;

    // Stage 1
    alu_issue_stage u_issue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .req_o       (issue_req)
    );

    // Both units see every request and zero out foreign ops
    int_datapath u_int (
        .req_i    (issue_req),
        .result_o (int_result),
        .branch_o (int_branch)
    );

    polar_simd_unit u_polar (
        .req_i    (issue_req),
        .result_o (polar_result)
    );

    // Stage 2
    alu_writeback_stage u_wb (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .valid_i        (issue_req.valid),
        .unit_i         (issue_req.unit),
        .int_result_i   (int_result),
        .polar_result_i (polar_result),
        .int_branch_i   (int_branch),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .branch_o       (branch_o)
    );

endmodule

//--- hw/alu_writeback_stage.sv
/* Output register of the ALU pipeline.
   Picks the result of the owning unit and holds it until the next strobe. */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_writeback_stage
    import alu_op_pkg::*;
    import polar_lane_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  unit_sel_e            unit_i,
    input  logic [`ALU_XLEN-1:0] int_result_i,
    input  logic [`ALU_XLEN-1:0] polar_result_i,
    input  logic                 int_branch_i,
    output logic                 valid_o,
    output logic [`ALU_XLEN-1:0] result_o,
    output logic                 branch_o
);

    logic [`ALU_XLEN-1:0] result_d;

    assign result_d = (unit_i == POLAR_UNIT) ? polar_result_i : int_result_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            branch_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            // Outputs hold between strobes
            if (valid_i) begin
                result_o <= result_d;
                branch_o <= int_branch_i;
            end
        end
    end

    // Unit tag from issue must agree with the decode of both units
    a_foreign_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> ((unit_i == POLAR_UNIT) ? (int_result_i == '0)
                                            : (polar_result_i == '0)));

endmodule

//--- hw/polar_simd_unit.sv
/* Four-lane polar-code unit for successive-cancellation decoding steps.
   Combinational; works on the lane view of the issued operands. */
`timescale 1ns/1ps
`include "alu_consts.svh"

module polar_simd_unit
    import alu_op_pkg::*;
    import polar_lane_pkg::*;
(
    input  alu_req_t             req_i,
    output logic [`ALU_XLEN-1:0] result_o
);

    lane_t     b_ctl;
    logic      r_kill;
    logic      dec_pass;
    alu_word_u f_word;
    alu_word_u r_word;
    alu_word_u add_word;
    alu_word_u sub_word;
    alu_word_u eval_word;
    alu_word_u dec_word;

    // Clamp a 9-bit lane result to the symmetric range
    function automatic lane_t sat_lane(input logic signed [`ALU_LANE_W:0] value);
        lane_t clamped;
        if (value > `ALU_SAT_MAX) begin
            clamped = lane_t'(`ALU_SAT_MAX);
        end else if (value < -`ALU_SAT_MAX) begin
            clamped = lane_t'(-`ALU_SAT_MAX);
        end else begin
            clamped = value[`ALU_LANE_W-1:0];
        end
        return clamped;
    endfunction

    // Lane 0 of operand b doubles as a control byte for R and DECODE
    assign b_ctl    = req_i.operand_b.lanes[0];
    assign r_kill   = (b_ctl == lane_t'(1));
    assign dec_pass = (b_ctl == lane_t'(0));

    // ------------------------------------------------------------
    // Per-lane datapath
    // ------------------------------------------------------------

    for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
        lane_t                        a;
        lane_t                        b;
        logic [`ALU_LANE_W-1:0]       abs_a;
        logic [`ALU_LANE_W-1:0]       abs_b;
        logic [`ALU_LANE_W-1:0]       mag;
        logic                         sign;
        logic signed [`ALU_LANE_W:0]  sum;
        logic signed [`ALU_LANE_W:0]  diff;

        assign a = req_i.operand_a.lanes[i];
        assign b = req_i.operand_b.lanes[i];

        // f: min-sum check node, sign product times smaller magnitude
        assign abs_a = a[`ALU_LANE_W-1] ? -a : a;
        assign abs_b = b[`ALU_LANE_W-1] ? -b : b;
        assign sign  = a[`ALU_LANE_W-1] ^ b[`ALU_LANE_W-1];
        assign mag   = (abs_a > abs_b) ? abs_b : abs_a;
        assign f_word.lanes[i] = sign ? -mag : mag;

        // r: hard decision on the sign
        assign r_word.lanes[i] = r_kill ? '0 : {{(`ALU_LANE_W-1){1'b0}}, a[`ALU_LANE_W-1]};

        // Saturating add and sub keep one guard bit
        assign sum  = a + b;
        assign diff = a - b;
        assign add_word.lanes[i] = sat_lane(sum);
        assign sub_word.lanes[i] = sat_lane(diff);

        assign eval_word.lanes[i] = (a == lane_t'(1)) ? '1 : '0;
        assign dec_word.lanes[i]  = dec_pass ? a : '0;
    end

    always_comb begin
        case (req_i.op)
            PL_F:      result_o = f_word.scalar;
            PL_R:      result_o = r_word.scalar;
            PL_ADDSAT: result_o = add_word.scalar;
            PL_SUBSAT: result_o = sub_word.scalar;
            PL_EVAL:   result_o = eval_word.scalar;
            PL_DECODE: result_o = dec_word.scalar;
            default:   result_o = '0;
        endcase
    end

endmodule

//--- hw/int_datapath.sv
/* Integer half of the execute stage: adder, logic ops, compare and branch resolve.
   Purely combinational, fed by the issued request. */
`timescale 1ns/1ps
`include "alu_consts.svh"

module int_datapath
    import alu_op_pkg::*;
    import polar_lane_pkg::*;
(
    input  alu_req_t             req_i,
    output logic [`ALU_XLEN-1:0] result_o,
    output logic                 branch_o
);

    logic [`ALU_XLEN-1:0] op_a;
    logic [`ALU_XLEN-1:0] op_b;
    logic                 negate_b;
    logic [`ALU_XLEN:0]   adder_in_a;
    logic [`ALU_XLEN:0]   adder_in_b;
    logic [`ALU_XLEN:0]   adder_sum;
    logic [`ALU_XLEN-1:0] adder_result;
    logic                 zero_flag;
    logic                 signed_cmp;
    logic                 less;

    assign op_a = req_i.operand_a.scalar;
    assign op_b = req_i.operand_b.scalar;

    // ------------------------------------------------------------
    // Shared adder
    // ------------------------------------------------------------

    assign negate_b = (req_i.op == SUB) || (req_i.op == EQ) || (req_i.op == NE);

    // Extra LSB on both inputs supplies the +1 of two's complement
    assign adder_in_a   = {op_a, 1'b1};
    assign adder_in_b   = {op_b, 1'b0} ^ {(`ALU_XLEN+1){negate_b}};
    assign adder_sum    = adder_in_a + adder_in_b;
    assign adder_result = adder_sum[`ALU_XLEN:1];
    assign zero_flag    = ~|adder_result;

    // ------------------------------------------------------------
    // Shared comparator
    // ------------------------------------------------------------

    assign signed_cmp = (req_i.op == SLTS) || (req_i.op == LTS) || (req_i.op == GES);

    // One extra bit turns both forms into a signed compare
    assign less = $signed({signed_cmp & op_a[`ALU_XLEN-1], op_a})
                < $signed({signed_cmp & op_b[`ALU_XLEN-1], op_b});

    always_comb begin
        result_o = '0;
        case (req_i.op)
            ADD, SUB:   result_o = adder_result;
            AND_L:      result_o = op_a & op_b;
            OR_L:       result_o = op_a | op_b;
            XOR_L:      result_o = op_a ^ op_b;
            SLTS, SLTU: result_o = {{(`ALU_XLEN-1){1'b0}}, less};
            default:    result_o = '0;
        endcase
    end

    // Taken by default for anything that is not a branch
    always_comb begin
        case (req_i.op)
            EQ:       branch_o = zero_flag;
            NE:       branch_o = ~zero_flag;
            LTS, LTU: branch_o = less;
            GES, GEU: branch_o = ~less;
            default:  branch_o = 1'b1;
        endcase
    end

endmodule

//--- hw/alu_issue_stage.sv
/* Input register of the ALU pipeline.
   Captures each strobed operation and tags it with the unit that executes it. */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_issue_stage
    import alu_op_pkg::*;
    import polar_lane_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  alu_op_e              op_i,
    input  logic [`ALU_XLEN-1:0] operand_a_i,
    input  logic [`ALU_XLEN-1:0] operand_b_i,
    output alu_req_t             req_o
);

    unit_sel_e unit_d;

    // Polar ops run on the lane unit, everything else on the integer unit
    always_comb begin
        case (op_i)
            PL_F, PL_R, PL_ADDSAT, PL_SUBSAT, PL_EVAL, PL_DECODE: unit_d = POLAR_UNIT;
            default: unit_d = INT_UNIT;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_o.valid <= 1'b0;
        end else begin
            req_o.valid <= valid_i;
        end
        // Payload only moves on a strobe
        if (valid_i) begin
            req_o.op               <= op_i;
            req_o.unit             <= unit_d;
            req_o.operand_a.scalar <= operand_a_i;
            req_o.operand_b.scalar <= operand_b_i;
        end
    end

    // Encodings 19..31 are unused
    a_legal_op: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i |-> op_i inside {[ADD:PL_DECODE]});

endmodule

//--- hw/alu_op_pkg.sv
/* Operator encodings and the issued request record of the ALU.
   Shared by the issue stage, both processing units and writeback. */
package alu_op_pkg;

    import polar_lane_pkg::*;

    // ------------------------------------------------------------
    // Operators
    // ------------------------------------------------------------

    typedef enum logic [4:0] {
        // Adder and logic
        ADD       = 5'd0,
        SUB       = 5'd1,
        AND_L     = 5'd2,
        OR_L      = 5'd3,
        XOR_L     = 5'd4,
        // Set less than
        SLTS      = 5'd5,
        SLTU      = 5'd6,
        // Branch resolution
        EQ        = 5'd7,
        NE        = 5'd8,
        LTS       = 5'd9,
        LTU       = 5'd10,
        GES       = 5'd11,
        GEU       = 5'd12,
        // Polar lane ops
        PL_F      = 5'd13,
        PL_R      = 5'd14,
        PL_ADDSAT = 5'd15,
        PL_SUBSAT = 5'd16,
        PL_EVAL   = 5'd17,
        PL_DECODE = 5'd18
    } alu_op_e;

    // Unit that owns the result
    typedef enum logic {
        INT_UNIT   = 1'b0,
        POLAR_UNIT = 1'b1
    } unit_sel_e;

    // Request as seen by the processing units
    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        unit_sel_e unit;
        alu_word_u operand_a;
        alu_word_u operand_b;
    } alu_req_t;

endpackage

//--- hw/polar_lane_pkg.sv
/* Lane types for the polar SIMD extension.
   A word is read either as one scalar or as four signed lanes. */
`include "alu_consts.svh"

package polar_lane_pkg;

    // One signed polar lane
    typedef logic signed [`ALU_LANE_W-1:0] lane_t;

    // ------------------------------------------------------------
    // Word views
    // ------------------------------------------------------------

    // The integer unit reads scalar, the polar unit reads lanes.
    // Lane 0 sits in bits 7:0
    typedef union packed {
        logic [`ALU_XLEN-1:0]     scalar;
        lane_t [`ALU_LANES-1:0]   lanes;
    } alu_word_u;

endpackage

//--- hw/alu_consts.svh
/* Width and saturation constants for the polar ALU.
   Include wherever a datapath, lane or clamp size is needed. */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// ------------------------------------------------------------
// Datapath
// ------------------------------------------------------------

// Scalar word width
`define ALU_XLEN 32

// ------------------------------------------------------------
// Polar SIMD lanes
// ------------------------------------------------------------

// Signed lane width
`define ALU_LANE_W 8

// Lanes per word
`define ALU_LANES (`ALU_XLEN / `ALU_LANE_W)

// Symmetric clamp, so -128 never leaves a saturating op
`define ALU_SAT_MAX 127

`endif
